/* hw/r5p_pkg.sv */
`default_nettype none

package r5p_pkg;

  //////////////////////////////
  // major opcodes
  //////////////////////////////

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OPI    = 7'b0010011,  // register-immediate ALU
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,  // register-register ALU
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opc_t;

  //////////////////////////////
  // control selectors
  //////////////////////////////

  // ALU op, coded as {funct7[5], funct3} so the decoder can pass fields through
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0000,
    AO_SLL  = 4'b0001,
    AO_SLT  = 4'b0010,
    AO_SLTU = 4'b0011,
    AO_XOR  = 4'b0100,
    AO_SRL  = 4'b0101,
    AO_OR   = 4'b0110,
    AO_AND  = 4'b0111,
    AO_SUB  = 4'b1000,
    AO_SRA  = 4'b1101,
    AO_PS2  = 4'b1111   // pass operand 2, LUI
  } ao_t;

  typedef enum logic [2:0] {
    BR_NONE,  // never taken
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_ALW    // jumps
  } br_t;

  typedef enum logic {A1_RS1, A1_PC } a1_t;   // ALU operand 1
  typedef enum logic {A2_RS2, A2_IMM} a2_t;   // ALU operand 2
  typedef enum logic {PC_PCN, PC_ALU} pc_t;   // next PC

  typedef enum logic [1:0] {
    WB_NON,  // no write back
    WB_ALU,
    WB_MEM,
    WB_PCN   // PC+4, link
  } wb_t;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2
  } sz_t;

  //////////////////////////////
  // decoded control
  //////////////////////////////

  typedef struct packed {
    logic en;  // access enable
    logic we;  // store
    logic sg;  // sign extend load
    sz_t  sz;
  } ls_ctl_t;

  typedef struct packed {
    logic       rs1_en;
    logic       rs2_en;
    logic       rd_en;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
  } gpr_ctl_t;

  typedef struct packed {
    ao_t         ao;
    br_t         br;
    a1_t         a1;
    a2_t         a2;
    pc_t         pc;
    wb_t         wb;
    ls_ctl_t     ls;
    gpr_ctl_t    gpr;
    logic [31:0] imm;
    logic        ill;  // unsupported encoding
  } ctl_t;

endpackage

`default_nettype wire

/* hw/r5p_dec.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_dec (
  input  logic [31:0]   op,
  output r5p_pkg::ctl_t ctl
);

  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign f3 = op[14:12];
  assign f7 = op[31:25];

  //////////////////////////////
  // immediates
  //////////////////////////////

  assign imm_i = {{20{op[31]}}, op[31:20]};
  assign imm_s = {{20{op[31]}}, op[31:25], op[11:7]};
  assign imm_b = {{19{op[31]}}, op[31], op[7], op[30:25], op[11:8], 1'b0};
  assign imm_u = {op[31:12], 12'h000};
  assign imm_j = {{11{op[31]}}, op[31], op[19:12], op[20], op[30:21], 1'b0};

  //////////////////////////////
  // control
  //////////////////////////////

  always_comb begin
    ctl = '0;              // nop, no enables
    ctl.ao = r5p_pkg::AO_ADD;
    ctl.br = r5p_pkg::BR_NONE;
    ctl.a1 = r5p_pkg::A1_RS1;
    ctl.a2 = r5p_pkg::A2_IMM;
    ctl.pc = r5p_pkg::PC_PCN;
    ctl.wb = r5p_pkg::WB_NON;
    ctl.gpr.rs1 = op[19:15];
    ctl.gpr.rs2 = op[24:20];
    ctl.gpr.rd  = op[11:7];
    case (r5p_pkg::opc_t'(op[6:0]))
      r5p_pkg::OPC_LUI: begin
        ctl.ao = r5p_pkg::AO_PS2;
        ctl.imm = imm_u;
        ctl.wb = r5p_pkg::WB_ALU;
        ctl.gpr.rd_en = 1'b1;
      end
      r5p_pkg::OPC_AUIPC: begin
        ctl.a1 = r5p_pkg::A1_PC;
        ctl.imm = imm_u;
        ctl.wb = r5p_pkg::WB_ALU;
        ctl.gpr.rd_en = 1'b1;
      end
      r5p_pkg::OPC_JAL: begin
        ctl.a1 = r5p_pkg::A1_PC;    // target pc+imm
        ctl.imm = imm_j;
        ctl.br = r5p_pkg::BR_ALW;
        ctl.pc = r5p_pkg::PC_ALU;
        ctl.wb = r5p_pkg::WB_PCN;   // link
        ctl.gpr.rd_en = 1'b1;
      end
      r5p_pkg::OPC_JALR: begin
        ctl.imm = imm_i;            // target rs1+imm
        ctl.br = r5p_pkg::BR_ALW;
        ctl.pc = r5p_pkg::PC_ALU;
        ctl.wb = r5p_pkg::WB_PCN;
        ctl.gpr.rs1_en = 1'b1;
        ctl.gpr.rd_en = 1'b1;
        ctl.ill = (f3 != 3'b000);
      end
      r5p_pkg::OPC_BRANCH: begin
        ctl.a1 = r5p_pkg::A1_PC;
        ctl.imm = imm_b;
        ctl.pc = r5p_pkg::PC_ALU;
        ctl.gpr.rs1_en = 1'b1;
        ctl.gpr.rs2_en = 1'b1;
        case (f3)
          3'b000:  ctl.br = r5p_pkg::BR_EQ;
          3'b001:  ctl.br = r5p_pkg::BR_NE;
          3'b100:  ctl.br = r5p_pkg::BR_LT;
          3'b101:  ctl.br = r5p_pkg::BR_GE;
          3'b110:  ctl.br = r5p_pkg::BR_LTU;
          3'b111:  ctl.br = r5p_pkg::BR_GEU;
          default: ctl.ill = 1'b1;
        endcase
      end
      r5p_pkg::OPC_LOAD: begin
        ctl.imm = imm_i;
        ctl.wb = r5p_pkg::WB_MEM;
        ctl.gpr.rs1_en = 1'b1;
        ctl.gpr.rd_en = 1'b1;
        ctl.ls.en = 1'b1;
        ctl.ls.sg = ~f3[2];         // LBU/LHU clear it
        ctl.ls.sz = r5p_pkg::sz_t'(f3[1:0]);
        ctl.ill = (f3[1:0] == 2'b11) || (f3 == 3'b110);  // no LD, no LWU
      end
      r5p_pkg::OPC_STORE: begin
        ctl.imm = imm_s;
        ctl.gpr.rs1_en = 1'b1;
        ctl.gpr.rs2_en = 1'b1;
        ctl.ls.en = 1'b1;
        ctl.ls.we = 1'b1;
        ctl.ls.sz = r5p_pkg::sz_t'(f3[1:0]);
        ctl.ill = f3[2] || (f3[1:0] == 2'b11);
      end
      r5p_pkg::OPC_OPI: begin
        ctl.imm = imm_i;
        ctl.wb = r5p_pkg::WB_ALU;
        ctl.gpr.rs1_en = 1'b1;
        ctl.gpr.rd_en = 1'b1;
        ctl.ao = r5p_pkg::ao_t'({(f3 == 3'b101) & f7[5], f3});  // imm[10] only for SRAI
        ctl.ill = ((f3 == 3'b001) && (f7 != 7'h00)) ||
                  ((f3 == 3'b101) && ((f7 & 7'h5f) != 7'h00));
      end
      r5p_pkg::OPC_OP: begin
        ctl.a2 = r5p_pkg::A2_RS2;
        ctl.wb = r5p_pkg::WB_ALU;
        ctl.gpr.rs1_en = 1'b1;
        ctl.gpr.rs2_en = 1'b1;
        ctl.gpr.rd_en = 1'b1;
        ctl.ao = r5p_pkg::ao_t'({f7[5], f3});
        ctl.ill = ((f7 & 7'h5f) != 7'h00) ||
                  (f7[5] && (f3 != 3'b000) && (f3 != 3'b101));  // SUB and SRA only
      end
      default: ctl.ill = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* hw/r5p_gpr.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_gpr #(
  parameter int unsigned XW = 32
)(
  input  logic              clk,
  input  logic              rst,
  input  r5p_pkg::gpr_ctl_t ctl,
  input  logic              wen,    // execute strobe
  input  logic [XW-1:0]     d_rd,
  output logic [XW-1:0]     d_rs1,
  output logic [XW-1:0]     d_rs2
);

  logic [XW-1:0] gpr [1:31];  // no storage for x0

  // write port
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        gpr[i] <= '0;
      end
    end else if (wen && ctl.rd_en && (ctl.rd != 5'd0)) begin
      gpr[ctl.rd] <= d_rd;
    end
  end

  // read ports, x0 and unused sources read zero
  always_comb begin
    d_rs1 = '0;
    d_rs2 = '0;
    if (ctl.rs1_en && (ctl.rs1 != 5'd0)) d_rs1 = gpr[ctl.rs1];
    if (ctl.rs2_en && (ctl.rs2 != 5'd0)) d_rs2 = gpr[ctl.rs2];
  end

endmodule

`default_nettype wire

/* hw/r5p_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_alu #(
  parameter int unsigned XW = 32
)(
  input  r5p_pkg::ao_t  ao,
  input  logic [XW-1:0] rs1,
  input  logic [XW-1:0] rs2,
  output logic [XW-1:0] rd,
  output logic [XW-1:0] sum   // plain add, addresses and jump targets
);

  localparam int unsigned SHW = $clog2(XW);

  logic [SHW-1:0] sha;  // shift amount

  assign sha = rs2[SHW-1:0];
  assign sum = rs1 + rs2;

  always_comb begin
    case (ao)
      r5p_pkg::AO_ADD:  rd = sum;
      r5p_pkg::AO_SUB:  rd = rs1 - rs2;
      r5p_pkg::AO_SLL:  rd = rs1 << sha;
      r5p_pkg::AO_SLT:  rd = XW'($signed(rs1) < $signed(rs2));
      r5p_pkg::AO_SLTU: rd = XW'(rs1 < rs2);
      r5p_pkg::AO_XOR:  rd = rs1 ^ rs2;
      r5p_pkg::AO_SRL:  rd = rs1 >> sha;
      r5p_pkg::AO_SRA:  rd = $unsigned($signed(rs1) >>> sha);
      r5p_pkg::AO_OR:   rd = rs1 | rs2;
      r5p_pkg::AO_AND:  rd = rs1 & rs2;
      r5p_pkg::AO_PS2:  rd = rs2;  // LUI immediate
      default:          rd = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/r5p_br.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_br #(
  parameter int unsigned XW = 32
)(
  input  r5p_pkg::br_t  br,
  input  logic [XW-1:0] rs1,
  input  logic [XW-1:0] rs2,
  output logic          tkn   // branch taken
);

  always_comb begin
    case (br)
      r5p_pkg::BR_EQ:  tkn = (rs1 == rs2);
      r5p_pkg::BR_NE:  tkn = (rs1 != rs2);
      r5p_pkg::BR_LT:  tkn = ($signed(rs1) <  $signed(rs2));
      r5p_pkg::BR_GE:  tkn = ($signed(rs1) >= $signed(rs2));
      r5p_pkg::BR_LTU: tkn = (rs1 <  rs2);
      r5p_pkg::BR_GEU: tkn = (rs1 >= rs2);
      r5p_pkg::BR_ALW: tkn = 1'b1;   // JAL, JALR
      default:         tkn = 1'b0;   // not a branch
    endcase
  end

endmodule

`default_nettype wire

/* hw/r5p_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_lsu #(
  parameter int unsigned XW = 32,
  parameter int unsigned DW = 32
)(
  input  r5p_pkg::ls_ctl_t ctl,
  input  logic [XW-1:0]    adr,       // byte address from ALU sum
  input  logic [XW-1:0]    wdt,       // rs2
  input  logic [DW-1:0]    bus_rdt,
  output logic [DW/8-1:0]  sel,
  output logic [XW-1:0]    bus_adr,
  output logic [DW-1:0]    bus_wdt,
  output logic [XW-1:0]    rdt        // extended load data
);

  localparam int unsigned SW = DW/8;
  localparam int unsigned OW = $clog2(SW);  // byte offset width

  logic [OW-1:0] off;
  logic [SW-1:0] lanes;   // select pattern before shift
  logic [XW-1:0] wmask;
  logic [DW-1:0] rtmp;    // read data moved down to lane 0

  assign off = adr[OW-1:0];
  assign bus_adr = {adr[XW-1:OW], {OW{1'b0}}};  // word aligned

  //////////////////////////////
  // store lanes
  //////////////////////////////

  always_comb begin
    case (ctl.sz)
      r5p_pkg::SZ_B: begin
        lanes = SW'(1);
        wmask = XW'(8'hff);
      end
      r5p_pkg::SZ_H: begin
        lanes = SW'(3);
        wmask = XW'(16'hffff);
      end
      r5p_pkg::SZ_W: begin
        lanes = SW'(15);
        wmask = XW'(32'hffff_ffff);
      end
      default: begin
        lanes = '0;      // no such size
        wmask = '0;
      end
    endcase
  end

  assign sel = ctl.en ? (lanes << off) : '0;
  assign bus_wdt = DW'(wdt & wmask) << (8*off);

  //////////////////////////////
  // load extract
  //////////////////////////////

  assign rtmp = bus_rdt >> (8*off);

  always_comb begin
    case (ctl.sz)
      r5p_pkg::SZ_B: rdt = {{(XW-8){ctl.sg & rtmp[7]}}, rtmp[7:0]};
      r5p_pkg::SZ_H: rdt = {{(XW-16){ctl.sg & rtmp[15]}}, rtmp[15:0]};
      default:       rdt = XW'(rtmp);   // word
    endcase
  end

endmodule

`default_nettype wire

/* hw/r5p_core.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_core #(
  parameter int unsigned XW  = 32,
  parameter int unsigned DW  = 32,
  parameter logic [31:0] PC0 = 32'h0000_0000
)(
  input  logic            clk,
  input  logic            rst,
  // program bus
  output logic            if_req,
  output logic [31:0]     if_adr,
  input  logic [31:0]     if_rdt,
  input  logic            if_ack,
  // data bus
  output logic            ls_req,
  output logic            ls_wen,
  output logic [31:0]     ls_adr,
  output logic [DW/8-1:0] ls_sel,
  output logic [DW-1:0]   ls_wdt,
  input  logic [DW-1:0]   ls_rdt,
  input  logic            ls_ack
);

  logic          id_vld;   // fetch acked last cycle
  logic          exe;      // execute strobe
  logic [31:0]   if_pc;
  logic [31:0]   pc_inc;   // pc+4
  logic [31:0]   if_pcn;   // next pc
  logic [31:0]   jmp_tgt;
  logic          br_tkn;
  logic          gpr_wen;
  logic [XW-1:0] gpr_rs1, gpr_rs2, gpr_rd;
  logic [XW-1:0] alu_rs1, alu_rs2, alu_rd, alu_sum;
  logic [XW-1:0] lsu_adr, lsu_rdt;

  r5p_pkg::ctl_t id_ctl;

  //////////////////////////////
  // fetch and pc
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      if_req <= 1'b0;
      id_vld <= 1'b0;
    end else begin
      if_req <= 1'b1;               // stays up once out of reset
      id_vld <= if_req & if_ack;
    end
  end

  // ill encodings retire nothing and refetch themselves
  assign exe = id_vld & if_ack & ~id_ctl.ill;

  always_ff @(posedge clk or posedge rst) begin
    if (rst)      if_pc <= PC0;
    else if (exe) if_pc <= if_pcn;
  end

  assign pc_inc = if_pc + 32'd4;
  assign jmp_tgt = {alu_sum[31:1], 1'b0};  // bit 0 only ever set by JALR

  always_comb begin
    if (!exe)                                              if_pcn = if_pc;  // stall
    else if ((id_ctl.pc == r5p_pkg::PC_ALU) && br_tkn)    if_pcn = jmp_tgt;
    else                                                   if_pcn = pc_inc;
  end

  assign if_adr = if_pcn;

  //////////////////////////////
  // decode and execute
  //////////////////////////////

  r5p_dec dec (
    .op  (if_rdt),
    .ctl (id_ctl)
  );

  // a load without ack writes nothing back
  assign gpr_wen = exe & ((id_ctl.wb != r5p_pkg::WB_MEM) | ls_ack);

  r5p_gpr #(.XW(XW)) gpr (
    .clk   (clk),
    .rst   (rst),
    .ctl   (id_ctl.gpr),
    .wen   (gpr_wen),
    .d_rd  (gpr_rd),
    .d_rs1 (gpr_rs1),
    .d_rs2 (gpr_rs2)
  );

  // operand muxes
  assign alu_rs1 = (id_ctl.a1 == r5p_pkg::A1_PC)  ? XW'(if_pc)  : gpr_rs1;
  assign alu_rs2 = (id_ctl.a2 == r5p_pkg::A2_IMM) ? XW'(id_ctl.imm) : gpr_rs2;

  r5p_alu #(.XW(XW)) alu (
    .ao  (id_ctl.ao),
    .rs1 (alu_rs1),
    .rs2 (alu_rs2),
    .rd  (alu_rd),
    .sum (alu_sum)
  );

  // compares registers while the ALU forms the target
  r5p_br #(.XW(XW)) br (
    .br  (id_ctl.br),
    .rs1 (gpr_rs1),
    .rs2 (gpr_rs2),
    .tkn (br_tkn)
  );

  //////////////////////////////
  // load/store
  //////////////////////////////

  r5p_lsu #(.XW(XW), .DW(DW)) lsu (
    .ctl     (id_ctl.ls),
    .adr     (alu_sum),
    .wdt     (gpr_rs2),
    .bus_rdt (ls_rdt),
    .sel     (ls_sel),
    .bus_adr (lsu_adr),
    .bus_wdt (ls_wdt),
    .rdt     (lsu_rdt)
  );

  assign ls_req = exe & id_ctl.ls.en;
  assign ls_wen = exe & id_ctl.ls.we;
  assign ls_adr = 32'(lsu_adr);

  // write-back mux
  always_comb begin
    case (id_ctl.wb)
      r5p_pkg::WB_ALU: gpr_rd = alu_rd;
      r5p_pkg::WB_MEM: gpr_rd = lsu_rdt;
      r5p_pkg::WB_PCN: gpr_rd = XW'(pc_inc);   // link address
      default:         gpr_rd = '0;
    endcase
  end

endmodule

`default_nettype wire

/* testbench/r5p_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_core_asserts (
  input logic        clk,
  input logic        rst,
  input logic        if_req,
  input logic        if_ack,
  input logic [31:0] if_adr,
  input logic        ls_req,
  input logic        ls_ack
);

  // data bus has no wait states
  ls_ack_with_req: assert property (@(posedge clk) disable iff (rst) ls_req |-> ls_ack)
    else $error("ls_req without ls_ack");

  // fetch request stays up once out of reset
  if_req_no_fall: assert property (@(posedge clk) disable iff (rst) !$fell(if_req))
    else $error("if_req dropped after reset");

  // stalled fetch, no data access and same address
  stall_no_ls: assert property (@(posedge clk) disable iff (rst) !if_ack |-> !ls_req)
    else $error("ls_req raised while if_ack low");

  stall_adr_hold: assert property (@(posedge clk) disable iff (rst) !if_ack |-> $stable(if_adr))
    else $error("if_adr moved while if_ack low");

endmodule

bind r5p_core r5p_core_asserts r5p_core_asserts_i (
  .clk    (clk),
  .rst    (rst),
  .if_req (if_req),
  .if_ack (if_ack),
  .if_adr (if_adr),
  .ls_req (ls_req),
  .ls_ack (ls_ack)
);

`default_nettype wire

/* testbench/r5p_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module r5p_tb;

  localparam int          CLK_PERIOD  = 8;
  localparam int          PROG_LEN    = 256;
  localparam int          WDOG_CYCLES = 4 * PROG_LEN * 2;
  localparam logic [31:0] PC0         = 32'h0000_0000;

  typedef struct packed {
    logic        ld;
    logic        st;
    logic [31:0] adr;   // word aligned
    logic [3:0]  sel;
    logic [31:0] wdt;
  } acc_t;

  logic        clk, rst;
  logic        if_req, if_ack;
  logic [31:0] if_adr, if_rdt;
  logic        ls_req, ls_wen, ls_ack;
  logic [31:0] ls_adr, ls_wdt, ls_rdt;
  logic [3:0]  ls_sel;

  logic [31:0] prog    [0:PROG_LEN-1];
  logic [31:0] bus_mem [0:63];   // data memory behind the bus
  logic [31:0] ref_mem [0:63];   // model's own copy
  logic [31:0] ref_x   [0:31];
  logic [31:0] ref_pc;
  logic [31:0] exp_npc;
  acc_t        exp_acc;
  logic [31:0] rnd_state = 32'd41;
  int          value_errs = 0;
  int          other_errs = 0;

  r5p_core #(.XW(32), .DW(32), .PC0(PC0)) r5p_core_i (
    .clk    (clk),
    .rst    (rst),
    .if_req (if_req),
    .if_adr (if_adr),
    .if_rdt (if_rdt),
    .if_ack (if_ack),
    .ls_req (ls_req),
    .ls_wen (ls_wen),
    .ls_adr (ls_adr),
    .ls_sel (ls_sel),
    .ls_wdt (ls_wdt),
    .ls_rdt (ls_rdt),
    .ls_ack (ls_ack)
  );

  assign ls_rdt = bus_mem[ls_adr[7:2]];  // same-cycle read

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the program reached its final jump");
    $display("Testbench failed");
    $finish;
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic logic [31:0] rand32();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  function automatic int pick(input int n);
    return int'(rand32() >> 16) % n;  // upper bits of the LCG state
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic gen_program();
    int          kind, k, sz, v;
    logic [2:0]  f3;
    logic [4:0]  rd, ra, rb;
    logic [11:0] imm;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind = pick(10);
      rd = 5'(pick(32));
      ra = 5'(pick(32));
      rb = 5'(pick(32));
      f3 = 3'(pick(8));
      k = 1 + pick(4);                       // forward distance in words
      if (i + k > PROG_LEN - 1) k = PROG_LEN - 1 - i;
      case (kind)
        0, 1, 2: begin                       // register ALU
          prog[i] = {((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00,
                     rb, ra, f3, rd, 7'h33};
        end
        3, 4: begin                          // immediate ALU
          imm = 12'(rand32() >> 20);
          if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
          if (f3 == 3'd5) imm = {(pick(2) == 1) ? 7'h20 : 7'h00, imm[4:0]};
          prog[i] = i_word(imm, ra, f3, rd, 7'h13);
        end
        5: prog[i] = {20'(rand32() >> 12), rd, (pick(2) == 1) ? 7'h37 : 7'h17};
        6: begin                             // x0 based store at a size aligned offset
          sz = pick(3);
          prog[i] = s_word(12'((pick(256) >> sz) << sz), rb, 5'd0, 3'(sz));
        end
        7: begin                             // signed or unsigned load
          sz = pick(3);
          f3 = 3'(sz);
          if (sz < 2 && pick(2) == 1) f3[2] = 1'b1;
          prog[i] = i_word(12'((pick(256) >> sz) << sz), 5'd0, f3, rd, 7'h03);
        end
        8: begin
          v = pick(6);
          f3 = 3'((v < 2) ? v : v + 2);     // beq bne blt bge bltu bgeu
          prog[i] = b_word(13'(4 * k), rb, ra, f3);
        end
        default: begin
          if (pick(2) == 1) prog[i] = j_word(21'(4 * k), rd);
          else prog[i] = i_word(12'(PC0 + 4 * (i + k)) | 12'(pick(2)), 5'd0, 3'd0, rd,
                                7'h67);  // low bit set half the time
        end
      endcase
    end
    prog[PROG_LEN-1] = j_word(21'd0, 5'd0);  // park
  endtask

  //////////////////////////////
  // instruction-set model
  //////////////////////////////

  task automatic iss_step(input logic [31:0] op);
    logic [31:0] a, b, res, adr, word;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]  f3;
    logic        tkn, wb;
    f3 = op[14:12];
    a = ref_x[op[19:15]];
    b = ref_x[op[24:20]];
    imm_i = {{20{op[31]}}, op[31:20]};
    imm_s = {{20{op[31]}}, op[31:25], op[11:7]};
    imm_b = {{19{op[31]}}, op[31], op[7], op[30:25], op[11:8], 1'b0};
    imm_u = {op[31:12], 12'h000};
    imm_j = {{11{op[31]}}, op[31], op[19:12], op[20], op[30:21], 1'b0};
    exp_npc = ref_pc + 32'd4;
    exp_acc = '0;
    res = '0;
    wb = 1'b1;
    tkn = 1'b0;
    case (op[6:0])
      7'h37: res = imm_u;
      7'h17: res = ref_pc + imm_u;
      7'h6f: begin
        res = ref_pc + 32'd4;
        exp_npc = ref_pc + imm_j;
      end
      7'h67: begin
        res = ref_pc + 32'd4;
        exp_npc = (a + imm_i) & ~32'h1;
      end
      7'h63: begin
        wb = 1'b0;
        case (f3)
          3'd0: tkn = (a == b);
          3'd1: tkn = (a != b);
          3'd4: tkn = ($signed(a) < $signed(b));
          3'd5: tkn = ($signed(a) >= $signed(b));
          3'd6: tkn = (a < b);
          default: tkn = (a >= b);
        endcase
        if (tkn) exp_npc = ref_pc + imm_b;
      end
      7'h03: begin
        adr = a + imm_i;
        word = ref_mem[adr[7:2]] >> (8 * adr[1:0]);
        case (f3)
          3'd0: res = {{24{word[7]}}, word[7:0]};
          3'd1: res = {{16{word[15]}}, word[15:0]};
          3'd4: res = {24'h0, word[7:0]};
          3'd5: res = {16'h0, word[15:0]};
          default: res = word;
        endcase
        exp_acc.ld = 1'b1;
        exp_acc.adr = {adr[31:2], 2'b00};
      end
      7'h23: begin
        wb = 1'b0;
        adr = a + imm_s;
        exp_acc.st = 1'b1;
        exp_acc.adr = {adr[31:2], 2'b00};
        case (f3)
          3'd0: begin
            exp_acc.sel = 4'b0001 << adr[1:0];
            exp_acc.wdt = {24'h0, b[7:0]} << (8 * adr[1:0]);
          end
          3'd1: begin
            exp_acc.sel = 4'b0011 << adr[1:0];
            exp_acc.wdt = {16'h0, b[15:0]} << (8 * adr[1:0]);
          end
          default: begin
            exp_acc.sel = 4'b1111;
            exp_acc.wdt = b;
          end
        endcase
        for (int j = 0; j < 4; j++) begin
          if (exp_acc.sel[j]) ref_mem[adr[7:2]][8*j +: 8] = exp_acc.wdt[8*j +: 8];
        end
      end
      default: begin                         // OP and OP-IMM
        if (!op[5]) b = imm_i;
        case (f3)
          3'd0: res = (op[5] && op[30]) ? a - b : a + b;  // sub needs register form
          3'd1: res = a << b[4:0];
          3'd2: res = {31'h0, $signed(a) < $signed(b)};
          3'd3: res = {31'h0, a < b};
          3'd4: res = a ^ b;
          3'd5: res = op[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
    endcase
    if (wb && op[11:7] != 5'd0) ref_x[op[11:7]] = res;
    ref_pc = exp_npc;
  endtask

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
    value_errs++;
    $display("** Error [%s] expected %08h, actual %08h", name, exp, act);
  endtask

  task automatic protocol_error(input string what);
    other_errs++;
    $display("** Error: %s", what);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else value_error(name, exp, act);
  endtask

  //////////////////////////////
  // bus models and checks
  //////////////////////////////

  initial begin : run_test
    logic        fetch_vld;   // fetch captured last edge
    logic [31:0] fetch_adr;
    logic        prev_ack;    // mirrors the core's id_vld
    logic        exec;
    logic        seen_ack;
    int          ncyc;
    int          n_exec;
    int          n_final;
    rst = 1'b1;
    if_ack = 1'b0;
    if_rdt = '0;
    ls_ack = 1'b1;                           // memory never waits
    fetch_vld = 1'b0;
    fetch_adr = '0;
    prev_ack = 1'b0;
    seen_ack = 1'b0;
    ncyc = 0;
    n_exec = 0;
    n_final = 0;
    gen_program();
    for (int w = 0; w < 64; w++) begin
      bus_mem[w] = {4{8'(w)}} ^ 32'h5a3c_c3a5;  // per-lane sign mix
      ref_mem[w] = bus_mem[w];
    end
    for (int r = 0; r < 32; r++) ref_x[r] = '0;
    ref_pc = PC0;

    while (n_final < 3) begin
      @(negedge clk);
      ncyc++;
      if (ncyc == 3) rst = 1'b0;             // 3 rising edges in reset
      // fetch answered one cycle after the request unless dropped
      if_ack = fetch_vld && (pick(8) != 0);
      if_rdt = if_ack ? prog[fetch_adr[9:2]] : rand32();
      #(CLK_PERIOD/4);                       // outputs settled well before the edge
      exec = prev_ack && if_ack && !rst;
      if (rst) begin
        assert (!if_req) else protocol_error("if_req high during reset");
      end
      if (if_ack && !seen_ack) begin
        seen_ack = 1'b1;
        check_eq("first fetch", PC0, fetch_adr);
      end
      if (!exec) begin
        assert (!ls_req) else protocol_error("ls_req raised outside an execute cycle");
        check_eq("if_adr hold", ref_pc, if_adr);
      end else begin
        check_eq("fetch address", ref_pc, fetch_adr);
        if (ref_pc == PC0 + 4 * (PROG_LEN - 1)) n_final++;
        iss_step(prog[ref_pc[9:2]]);
        n_exec++;
        check_eq("next pc", exp_npc, if_adr);
        check_eq("ls_req", 32'(exp_acc.ld | exp_acc.st), 32'(ls_req));
        if (exp_acc.ld || exp_acc.st) begin
          check_eq("ls_wen", 32'(exp_acc.st), 32'(ls_wen));
          check_eq("ls_adr", exp_acc.adr, ls_adr);
        end
        if (exp_acc.st) begin
          check_eq("ls_sel", 32'(exp_acc.sel), 32'(ls_sel));
          check_eq("ls_wdt", exp_acc.wdt, ls_wdt);
        end
      end
      if (ls_req && ls_wen) begin            // bus side write by lane
        for (int j = 0; j < 4; j++) begin
          if (ls_sel[j]) bus_mem[ls_adr[7:2]][8*j +: 8] = ls_wdt[8*j +: 8];
        end
      end
      prev_ack = if_req && if_ack;
      fetch_vld = if_req;
      fetch_adr = if_adr;
    end

    $display("errors: %0d value, %0d other, %0d instructions checked",
             value_errs, other_errs, n_exec);
    if (value_errs + other_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hw/r5p_pkg.sv
hw/r5p_dec.sv
hw/r5p_gpr.sv
hw/r5p_alu.sv
hw/r5p_br.sv
hw/r5p_lsu.sv
hw/r5p_core.sv
testbench/r5p_core_asserts.sv
testbench/r5p_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = r5p_tb
FILELIST = build.f
MDIR     = obj_dir
PASS_MSG = Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: build
	@out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR)
